// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    // 2 KB part, upper three bits ride in the control byte
    typedef logic [10:0] eeprom_addr_t;
    typedef logic [7:0]  byte_t;

    // host command, one per bus transaction
    typedef struct packed {
        logic         write;  // 1 = byte write, 0 = random read
        eeprom_addr_t addr;
        byte_t        wdata;
    } eeprom_cmd_t;

    // one response per command
    typedef struct packed {
        byte_t rdata;  // zero when nack is set
        logic  nack;
    } eeprom_rsp_t;

    // operations understood by the bit engine
    typedef enum logic [1:0] {
        OP_START = 2'd0,  // also used for the repeated start
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,  // 8 bits out, then sample the slave ack
        OP_READ  = 2'd3   // 8 bits in, then drive op_ack_out
    } bus_op_e;

    // device type code, control byte = {1010, a10..a8, r/w}
    localparam logic [3:0] ctrl_byte_base = 4'b1010;

endpackage

// ==== rtl/eeprom_cmd_queue.sv ====
module eeprom_cmd_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    input  logic                    q_pop,
    output logic                    q_valid,
    output eeprom_pkg::eeprom_cmd_t q_cmd,
    output logic                    cmd_credit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

    eeprom_pkg::eeprom_cmd_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;

    assign q_valid = (count != '0);
    assign q_cmd   = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            cmd_credit <= q_pop;  // one credit back per entry taken
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // host must never spend a credit it does not hold
    a_no_overflow: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> (count != FULL_CNT));

    a_no_underflow: assert property (@(posedge CLK) disable iff (RESET)
        q_pop |-> q_valid);

endmodule

// ==== rtl/i2c_bit_engine.sv ====
module i2c_bit_engine #(
    parameter int SCL_DIV = 4
) (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_req,
    input  eeprom_pkg::bus_op_e op,
    input  eeprom_pkg::byte_t   op_tx,
    input  logic                op_ack_out,
    input  logic                sda_in,
    output logic                op_done,
    output eeprom_pkg::byte_t   op_rx,
    output logic                op_nack,
    output logic                scl,
    output logic                sda_pull
);

    localparam int TICK_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(SCL_DIV - 1);

    // one bit = four quarters, scl low in q0 and q3
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_Q0,
        ST_Q1,
        ST_Q2,
        ST_Q3
    } phase_e;

    phase_e              state;
    logic [TICK_W-1:0]   tick_cnt;
    logic [3:0]          bit_cnt;
    eeprom_pkg::bus_op_e op_r;
    eeprom_pkg::byte_t   sh;
    logic                ack_out_r;
    logic                tick;
    logic                ack_slot;
    logic                last_bit;
    logic                sample;
    logic                scl_c;
    logic                pull_c;

    assign tick     = (tick_cnt == TICK_LAST);
    assign ack_slot = (bit_cnt == 4'd8);
    assign last_bit = (op_r == eeprom_pkg::OP_START || op_r == eeprom_pkg::OP_STOP) ? 1'b1
                                                                                 : ack_slot;
    assign sample   = (state == ST_Q2) && (tick_cnt == '0);  // mid scl high
    assign op_rx    = sh;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            op_done  <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (state == ST_IDLE) begin
                if (op_req) begin
                    state    <= ST_Q0;
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (!tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end else begin
                tick_cnt <= '0;
                case (state)
                    ST_Q0: state <= ST_Q1;
                    ST_Q1: state <= ST_Q2;
                    ST_Q2: state <= ST_Q3;
                    default: begin
                        if (last_bit) begin
                            state   <= ST_IDLE;
                            op_done <= 1'b1;
                        end else begin
                            state   <= ST_Q0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // shifter and captured ack
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && op_req) begin
            op_r      <= op;
            sh        <= op_tx;
            ack_out_r <= op_ack_out;
            op_nack   <= 1'b0;
        end else begin
            if (sample && !ack_slot && op_r == eeprom_pkg::OP_READ) begin
                sh <= {sh[6:0], sda_in};
            end
            if (sample && ack_slot && op_r == eeprom_pkg::OP_WRITE) begin
                op_nack <= sda_in;
            end
            if (state == ST_Q3 && tick && op_r == eeprom_pkg::OP_WRITE) begin
                sh <= {sh[6:0], 1'b0};  // next bit shows up in q0
            end
        end
    end

    // pins hold their level between operations
    always_comb begin
        scl_c  = scl;
        pull_c = sda_pull;
        if (state != ST_IDLE) begin
            scl_c = (state == ST_Q1) || (state == ST_Q2);
            case (op_r)
                eeprom_pkg::OP_START: begin
                    pull_c = (state == ST_Q2) || (state == ST_Q3);  // falls while scl high
                end
                eeprom_pkg::OP_STOP: begin
                    scl_c  = (state != ST_Q0);
                    pull_c = (state == ST_Q0) || (state == ST_Q1);  // rises while scl high
                end
                eeprom_pkg::OP_WRITE: pull_c = !ack_slot && !sh[7];  // released for slave ack
                default:              pull_c = ack_slot && !ack_out_r;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            scl      <= 1'b1;
            sda_pull <= 1'b0;
        end else begin
            scl      <= scl_c;
            sda_pull <= pull_c;
        end
    end

    // sequencer must wait for op_done before the next request
    a_req_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        op_req |-> (state == ST_IDLE));

endmodule

// ==== rtl/eeprom_seq.sv ====
module eeprom_seq (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    q_valid,
    input  eeprom_pkg::eeprom_cmd_t q_cmd,
    input  logic                    op_done,
    input  eeprom_pkg::byte_t       op_rx,
    input  logic                    op_nack,
    output logic                    q_pop,
    output logic                    op_req,
    output eeprom_pkg::bus_op_e     op,
    output eeprom_pkg::byte_t       op_tx,
    output logic                    op_ack_out,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_RESP
    } seq_state_e;

    seq_state_e              state;
    eeprom_pkg::eeprom_cmd_t cmd_r;
    logic                    go;  // request still to be issued in this state
    logic                    nack_r;
    eeprom_pkg::byte_t       rdata_r;
    logic [6:0]              ctrl_hi;

    assign ctrl_hi    = {eeprom_pkg::ctrl_byte_base, cmd_r.addr[10:8]};
    assign op_ack_out = (state == S_DATA_RD);  // single byte read ends with NACK
    assign rsp        = '{rdata: rdata_r, nack: nack_r};

    always_comb begin
        op    = eeprom_pkg::OP_WRITE;
        op_tx = '0;
        case (state)
            S_START, S_RESTART: op = eeprom_pkg::OP_START;
            S_CTRL_WR:          op_tx = {ctrl_hi, 1'b0};
            S_ADDR:             op_tx = cmd_r.addr[7:0];
            S_DATA_WR:          op_tx = cmd_r.wdata;
            S_CTRL_RD:          op_tx = {ctrl_hi, 1'b1};
            S_DATA_RD:          op = eeprom_pkg::OP_READ;
            default:            op = eeprom_pkg::OP_STOP;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (state == S_IDLE && q_valid) begin
            cmd_r <= q_cmd;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= S_IDLE;
            go        <= 1'b0;
            q_pop     <= 1'b0;
            op_req    <= 1'b0;
            rsp_valid <= 1'b0;
            nack_r    <= 1'b0;
            rdata_r   <= '0;
        end else begin
            q_pop     <= 1'b0;
            op_req    <= 1'b0;
            rsp_valid <= 1'b0;
            if (op_done) begin
                go <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (q_valid) begin
                        q_pop   <= 1'b1;
                        go      <= 1'b1;
                        nack_r  <= 1'b0;
                        rdata_r <= '0;
                        state   <= S_START;
                    end
                end
                S_RESP: begin
                    rsp_valid <= 1'b1;
                    state     <= S_IDLE;
                end
                default: begin
                    if (go) begin
                        op_req <= 1'b1;
                        go     <= 1'b0;
                    end else if (op_done) begin
                        case (state)
                            S_START:   state <= S_CTRL_WR;
                            S_CTRL_WR: state <= op_nack ? S_STOP : S_ADDR;
                            S_ADDR: begin
                                if (op_nack) begin
                                    state <= S_STOP;
                                end else begin
                                    state <= cmd_r.write ? S_DATA_WR : S_RESTART;
                                end
                            end
                            S_DATA_WR: state <= S_STOP;
                            S_RESTART: state <= S_CTRL_RD;
                            S_CTRL_RD: state <= op_nack ? S_STOP : S_DATA_RD;
                            S_DATA_RD: begin
                                rdata_r <= op_rx;
                                state   <= S_STOP;
                            end
                            default:   state <= S_RESP;
                        endcase
                        // any slave nack aborts to stop
                        if (op == eeprom_pkg::OP_WRITE && op_nack) begin
                            nack_r <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // refused transfer reports no data
    a_nack_zero_data: assert property (@(posedge CLK) disable iff (RESET)
        (rsp_valid && rsp.nack) |-> (rsp.rdata == '0));

endmodule

// ==== rtl/eeprom_ctrl_top.sv ====
module eeprom_ctrl_top #(
    parameter int QUEUE_DEPTH = 2,
    parameter int SCL_DIV     = 4
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    input  logic                    sda_in,
    output logic                    cmd_credit,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_pull
);

    logic                    q_valid;
    eeprom_pkg::eeprom_cmd_t q_cmd;
    logic                    q_pop;
    logic                    op_req;
    eeprom_pkg::bus_op_e     op;
    eeprom_pkg::byte_t       op_tx;
    logic                    op_ack_out;
    logic                    op_done;
    eeprom_pkg::byte_t       op_rx;
    logic                    op_nack;

    eeprom_cmd_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .q_pop      (q_pop),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .cmd_credit (cmd_credit)
    );

    eeprom_seq u_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .op_done    (op_done),
        .op_rx      (op_rx),
        .op_nack    (op_nack),
        .q_pop      (q_pop),
        .op_req     (op_req),
        .op         (op),
        .op_tx      (op_tx),
        .op_ack_out (op_ack_out),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    i2c_bit_engine #(
        .SCL_DIV(SCL_DIV)
    ) u_bit_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .op_req     (op_req),
        .op         (op),
        .op_tx      (op_tx),
        .op_ack_out (op_ack_out),
        .sda_in     (sda_in),
        .op_done    (op_done),
        .op_rx      (op_rx),
        .op_nack    (op_nack),
        .scl        (scl),
        .sda_pull   (sda_pull)
    );

endmodule

// ==== verif/eeprom_slave_model.sv ====
module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_inject,  // refuse the control byte
    output logic sda_pull
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } mode_e;

    eeprom_pkg::byte_t        mem [2048];
    mode_e                    mode;
    logic                     scl_q;
    logic                     sda_q;
    logic [3:0]               bit_cnt;
    eeprom_pkg::byte_t        shreg;
    logic                     ack_phase;
    logic [2:0]               block;
    eeprom_pkg::eeprom_addr_t addr;
    logic                     start_c;
    logic                     stop_c;
    logic                     rise;
    logic                     fall;

    // low address byte xor 5a, block number folded in
    initial begin
        for (int a = 0; a < 2048; a++) begin
            mem[a] = 8'(a) ^ 8'h5A ^ {5'b0, 3'(a >> 8)};
        end
    end

    assign start_c = scl && scl_q && sda_q && !sda;
    assign stop_c  = scl && scl_q && !sda_q && sda;
    assign rise    = scl && !scl_q;
    assign fall    = !scl && scl_q;

    always @(posedge CLK) begin
        if (RESET) begin
            mode      <= M_IDLE;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            bit_cnt   <= '0;
            ack_phase <= 1'b0;
            sda_pull  <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_c) begin
                mode      <= M_CTRL;
                bit_cnt   <= '0;
                ack_phase <= 1'b0;
                sda_pull  <= 1'b0;
            end else if (stop_c) begin
                mode      <= M_IDLE;
                ack_phase <= 1'b0;
                sda_pull  <= 1'b0;
            end else if (rise && mode != M_IDLE) begin
                if (mode == M_RDATA) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end else if (bit_cnt < 4'd8) begin
                    shreg   <= {shreg[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (fall && mode != M_IDLE) begin
                if (ack_phase) begin
                    ack_phase <= 1'b0;
                    bit_cnt   <= '0;
                    sda_pull  <= 1'b0;
                    if (mode == M_RDATA) begin
                        shreg    <= mem[addr];
                        sda_pull <= !mem[addr][7];  // msb first
                    end
                end else if (mode == M_RDATA) begin
                    if (bit_cnt < 4'd8) begin
                        shreg    <= {shreg[6:0], 1'b0};
                        sda_pull <= !shreg[6];
                    end else begin
                        sda_pull <= 1'b0;  // master ack slot
                    end
                end else if (bit_cnt == 4'd8) begin
                    ack_phase <= 1'b1;
                    sda_pull  <= 1'b1;
                    case (mode)
                        M_CTRL: begin
                            if (nack_inject || shreg[7:4] != 4'b1010) begin
                                ack_phase <= 1'b0;
                                sda_pull  <= 1'b0;
                                mode      <= M_IDLE;  // deaf until next start
                            end else begin
                                block <= shreg[3:1];
                                mode  <= shreg[0] ? M_RDATA : M_ADDR;
                            end
                        end
                        M_ADDR: begin
                            addr <= {block, shreg};
                            mode <= M_WDATA;
                        end
                        default: mem[addr] <= shreg;
                    endcase
                end
            end
        end
    end

endmodule

// ==== verif/tb_eeprom_ctrl.sv ====
module tb_eeprom_ctrl;

    localparam int QUEUE_DEPTH = 2;
    localparam int SCL_DIV     = 2;

    typedef struct packed {
        logic                     write;
        eeprom_pkg::eeprom_addr_t addr;
        eeprom_pkg::byte_t        wdata;
        logic                     inject;
        logic                     exp_nack;
        eeprom_pkg::byte_t        exp_data;
    } vector_t;

    logic                    CLK;
    logic                    RESET;
    logic                    cmd_valid;
    eeprom_pkg::eeprom_cmd_t cmd;
    logic                    cmd_credit;
    logic                    rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    scl;
    logic                    sda_pull_m;
    logic                    sda_pull_s;
    logic                    sda;
    logic                    nack_inject;

    vector_t vecs[$];
    vector_t pend[$];  // commands sent, response not yet seen
    vector_t cur;
    int      credits;
    int      n_sent;
    int      n_checked;
    int      gap;
    int      seed_val;
    int      cycle_cnt   = 0;
    int      cycle_limit = 1000000;

    assign sda = !(sda_pull_m || sda_pull_s);  // wired-and

    eeprom_ctrl_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .SCL_DIV    (SCL_DIV)
    ) dut (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .sda_in     (sda),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .scl        (scl),
        .sda_pull   (sda_pull_m)
    );

    eeprom_slave_model u_slave (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda),
        .nack_inject (nack_inject),
        .sda_pull    (sda_pull_s)
    );

    always #10 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        int      f_op;
        int      f_addr;
        int      f_wdata;
        int      f_inj;
        int      f_nack;
        int      f_data;
        vector_t v;
        fd = $fopen("verif/eeprom_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/eeprom_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_wdata,
                                 f_inj, f_nack, f_data) == 6) begin
                v = '{write: f_op[0], addr: f_addr[10:0], wdata: f_wdata[7:0],
                      inject: f_inj[0], exp_nack: f_nack[0], exp_data: f_data[7:0]};
                vecs.push_back(v);
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            abort_run("vector file holds no vectors");
        end
    endtask

    // slave refusal follows the oldest outstanding command
    task automatic select_inject();
        nack_inject = (pend.size() > 0) ? pend[0].inject : 1'b0;
    endtask

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("run hung, not done after %0d cycles", cycle_limit));
        end
    end

    initial begin
        seed_val    = $urandom(32'h95df);
        CLK         = 1'b0;
        RESET       = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        nack_inject = 1'b0;
        load_vectors();
        cycle_limit = vecs.size() * 60 * 4 * SCL_DIV + 200;
        repeat (10) @(posedge CLK);
        #2;
        RESET = 1'b0;
        @(posedge CLK);
        #2;
        check(scl, 1, "scl after reset");
        check(sda_pull_m, 0, "sda_pull after reset");
        check(rsp_valid, 0, "rsp_valid after reset");
        credits   = QUEUE_DEPTH;
        n_sent    = 0;
        n_checked = 0;
        gap       = $urandom_range(3, 0);
        while (n_checked < vecs.size()) begin
            cmd_valid = 1'b0;
            if (rsp_valid) begin
                check(pend.size() > 0, 1, "response with a command outstanding");
                cur = pend.pop_front();
                check(rsp.nack, cur.exp_nack, $sformatf("nack of vector %0d", n_checked));
                check(rsp.rdata, cur.exp_data, $sformatf("data of vector %0d", n_checked));
                n_checked++;
            end
            if (cmd_credit) begin
                credits++;
            end
            if (n_sent < vecs.size() && credits > 0) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    cur       = vecs[n_sent];
                    cmd_valid = 1'b1;
                    cmd       = '{write: cur.write, addr: cur.addr, wdata: cur.wdata};
                    pend.push_back(cur);
                    credits--;
                    n_sent++;
                    gap = $urandom_range(3, 0);
                end
            end
            check(credits >= 0 && credits <= QUEUE_DEPTH, 1, "credits within 0..depth");
            select_inject();
            @(posedge CLK);
            #2;
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verif/eeprom_vectors.txt ====
// op addr wdata inject exp_nack exp_data, all hex
// op 1 = byte write, 0 = random read; inject makes the slave nack the control byte
0 000 00 0 0 5a
0 7ff 00 0 0 a2
1 055 c3 0 0 00
0 055 00 0 0 c3
1 1a0 01 0 0 00
0 1a0 00 0 0 01
1 2ff 80 0 0 00
0 2ff 00 0 0 80
1 300 7e 0 0 00
0 300 00 0 0 7e
1 444 99 0 0 00
0 444 00 0 0 99
1 5bb 12 0 0 00
0 5bb 00 0 0 12
1 6c3 e7 0 0 00
0 6c3 00 0 0 e7
1 70f 00 0 0 00
0 70f 00 0 0 00
1 234 ff 1 1 00
0 234 00 0 0 6c

// ==== compile.f ====
rtl/eeprom_pkg.sv
rtl/eeprom_cmd_queue.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_seq.sv
rtl/eeprom_ctrl_top.sv
verif/eeprom_slave_model.sv
verif/tb_eeprom_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_eeprom_ctrl -o tb_eeprom_ctrl
./obj_dir/tb_eeprom_ctrl 2>&1 | tee sim.log
if grep -q "Verification failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation FAILED: no pass message in sim.log"
    exit 1
fi
echo "simulation PASSED"
